// File: Makefile
TOP := icache_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f verilog.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir

// File: src/icache_ctrl.sv
// Instruction cache controller with invalidate sweep, lookup, miss fetch, fill and victim pointer
`timescale 1ns/1ps

module icache_ctrl
    import icache_pkg::*;
#(
    parameter int  WAYS  = 2,
    parameter int  SETS  = 256,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = ADDR_W - 2 - IDX_W
) (
    input  logic              clk_i,
    input  logic              rst_i,

    // Fetch side
    input  logic              fetch_req_i,
    input  logic [ADDR_W-1:0] fetch_addr_i,
    output logic              ready_o,
    output logic              fetch_valid_o,
    output logic [DATA_W-1:0] fetch_data_o,

    // Memory side
    output logic              mem_req_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    input  logic              mem_rvalid_i,
    input  logic [DATA_W-1:0] mem_rdata_i,

    // Hit selector
    input  logic              hit_i,
    input  logic [DATA_W-1:0] hit_data_i,
    output logic [TAG_W-1:0]  lookup_tag_o,

    icache_way_if.ctrl        way_o [WAYS]
);

    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1;

    ctrl_state_e       state_q;
    ctrl_state_e       state_d;
    logic [IDX_W-1:0]  sweep_q;
    logic [ADDR_W-1:2] addr_q;       // Word address of the pending fetch
    logic [WAY_W-1:0]  victim_q;
    logic              fill_done_q;  // Response cycle of a miss
    logic [DATA_W-1:0] fill_data_q;
    logic [IDX_W-1:0]  rd_idx;
    logic [IDX_W-1:0]  wr_idx;
    logic              fill_we;
    logic              sweep_last;
    logic              take_req;

    assign take_req   = (state_q == ST_IDLE) && fetch_req_i;
    assign sweep_last = (sweep_q == IDX_W'(SETS - 1));
    assign fill_we    = (state_q == ST_FILL) && mem_rvalid_i && !fill_done_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_INIT: begin
                if (sweep_last) begin
                    state_d = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (fetch_req_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                state_d = hit_i ? ST_IDLE : ST_FILL;
            end
            ST_FILL: begin
                if (fill_done_q) begin  // Stay one more cycle to answer
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_INIT;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= ST_INIT;
            sweep_q     <= '0;
            victim_q    <= '0;
            fill_done_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            fill_done_q <= fill_we;
            if (state_q == ST_INIT) begin
                sweep_q <= sweep_q + 1'b1;
            end
            if (fill_we) begin
                victim_q <= (victim_q == WAY_W'(WAYS - 1)) ? '0 : victim_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_req) begin
            addr_q <= fetch_addr_i[ADDR_W-1:2];  // Byte offset dropped
        end
        if (fill_we) begin
            fill_data_q <= mem_rdata_i;
        end
    end

    // Banks read the incoming address while idle so tags are ready next cycle
    assign rd_idx = (state_q == ST_IDLE) ? fetch_addr_i[IDX_W+1:2] : addr_q[IDX_W+1:2];
    assign wr_idx = (state_q == ST_INIT) ? sweep_q : addr_q[IDX_W+1:2];

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        assign way_o[w].we      = (state_q == ST_INIT) || (fill_we && victim_q == WAY_W'(w));
        assign way_o[w].w_idx   = wr_idx;
        assign way_o[w].w_tag   = addr_q[ADDR_W-1:IDX_W+2];
        assign way_o[w].w_data  = mem_rdata_i;
        assign way_o[w].w_valid = (state_q != ST_INIT);  // Sweep writes invalid lines
        assign way_o[w].r_idx   = rd_idx;
    end

    assign lookup_tag_o  = addr_q[ADDR_W-1:IDX_W+2];
    assign ready_o       = (state_q == ST_IDLE);
    assign mem_req_o     = (state_q == ST_LOOKUP) && !hit_i;
    assign mem_addr_o    = {addr_q, 2'b00};
    assign fetch_valid_o = ((state_q == ST_LOOKUP) && hit_i) || fill_done_q;
    assign fetch_data_o  = fill_done_q ? fill_data_q : hit_data_i;

endmodule

// File: src/icache_hit_select.sv
// Cache hit selector comparing every way's tag and muxing out the word of the hit way
`timescale 1ns/1ps

module icache_hit_select
    import icache_pkg::*;
#(
    parameter int  WAYS  = 2,
    parameter int  SETS  = 256,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = ADDR_W - 2 - IDX_W
) (
    input  logic [TAG_W-1:0]  lookup_tag_i,
    icache_way_if.sel         way_i [WAYS],
    output logic              hit_o,
    output logic [DATA_W-1:0] hit_data_o
);

    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1;

    logic [WAYS-1:0]   match;
    logic [DATA_W-1:0] rd_data [WAYS];
    logic [WAY_W-1:0]  hit_way;

    for (genvar w = 0; w < WAYS; w++) begin : g_cmp
        assign match[w]   = way_i[w].r_valid && (way_i[w].r_tag == lookup_tag_i);
        assign rd_data[w] = way_i[w].r_data;
    end

    // Fills only follow misses, so a line lives in one way at most
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (match[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    assign hit_o      = |match;
    assign hit_data_o = rd_data[hit_way];

endmodule

// File: src/icache_pkg.sv
// Instruction cache package with bus widths and the controller state encoding
package icache_pkg;

    // Fetch address width, byte addressed
    parameter int ADDR_W = 32;

    // Instruction word width
    parameter int DATA_W = 32;

    // Controller states
    typedef enum logic [1:0] {
        ST_INIT,    // Sweeping valid bits clear after reset
        ST_IDLE,    // Ready for a fetch
        ST_LOOKUP,  // Bank outputs valid, tags compared
        ST_FILL     // Miss issued, waiting for memory data
    } ctrl_state_e;

endpackage

// File: src/icache_top.sv
// Set-associative instruction cache top level tying the controller, way banks and hit selector
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
#(
    parameter int WAYS = 2,
    parameter int SETS = 256
) (
    input  logic              clk_i,
    input  logic              rst_i,

    // Fetch side
    input  logic              fetch_req_i,
    input  logic [ADDR_W-1:0] fetch_addr_i,
    output logic              ready_o,
    output logic              fetch_valid_o,
    output logic [DATA_W-1:0] fetch_data_o,

    // Memory side
    output logic              mem_req_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    input  logic              mem_rvalid_i,
    input  logic [DATA_W-1:0] mem_rdata_i
);

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = ADDR_W - 2 - IDX_W;

    logic              hit;
    logic [DATA_W-1:0] hit_data;
    logic [TAG_W-1:0]  lookup_tag;

    icache_way_if #(
        .SETS  (SETS),
        .IDX_W (IDX_W),
        .TAG_W (TAG_W)
    ) way_if [WAYS] ();

    icache_ctrl #(
        .WAYS (WAYS),
        .SETS (SETS)
    ) i_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .ready_o       (ready_o),
        .fetch_valid_o (fetch_valid_o),
        .fetch_data_o  (fetch_data_o),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_rvalid_i  (mem_rvalid_i),
        .mem_rdata_i   (mem_rdata_i),
        .hit_i         (hit),
        .hit_data_i    (hit_data),
        .lookup_tag_o  (lookup_tag),
        .way_o         (way_if)
    );

    for (genvar w = 0; w < WAYS; w++) begin : g_bank
        icache_way_bank #(
            .SETS (SETS)
        ) i_bank (
            .clk_i  (clk_i),
            .way_io (way_if[w])
        );
    end

    icache_hit_select #(
        .WAYS (WAYS),
        .SETS (SETS)
    ) i_hit_select (
        .lookup_tag_i (lookup_tag),
        .way_i        (way_if),
        .hit_o        (hit),
        .hit_data_o   (hit_data)
    );

endmodule

// File: src/icache_way_bank.sv
// Cache way bank holding valid, tag and word storage with a one-cycle registered read
`timescale 1ns/1ps

module icache_way_bank
    import icache_pkg::*;
#(
    parameter int SETS = 256
) (
    input  logic       clk_i,
    icache_way_if.bank way_io
);

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = ADDR_W - 2 - IDX_W;

    logic [SETS-1:0]   valid_mem;  // Cleared by the controller sweep
    logic [TAG_W-1:0]  tag_mem [SETS];
    logic [DATA_W-1:0] data_mem [SETS];

    always_ff @(posedge clk_i) begin
        if (way_io.we) begin
            valid_mem[way_io.w_idx] <= way_io.w_valid;
            tag_mem[way_io.w_idx]   <= way_io.w_tag;
            data_mem[way_io.w_idx]  <= way_io.w_data;
        end
    end

    // Read returns the old contents when the same set is written in that cycle
    always_ff @(posedge clk_i) begin
        way_io.r_valid <= valid_mem[way_io.r_idx];
        way_io.r_tag   <= tag_mem[way_io.r_idx];
        way_io.r_data  <= data_mem[way_io.r_idx];
    end

endmodule

// File: src/icache_way_if.sv
// Cache way port bundle carrying the write side and registered read side of one way
`timescale 1ns/1ps

interface icache_way_if
    import icache_pkg::*;
#(
    parameter int SETS  = 256,
    parameter int IDX_W = $clog2(SETS),
    parameter int TAG_W = ADDR_W - 2 - IDX_W
);

    // Write side, owned by the controller
    logic              we;
    logic [IDX_W-1:0]  w_idx;
    logic [TAG_W-1:0]  w_tag;
    logic [DATA_W-1:0] w_data;
    logic              w_valid;

    logic [IDX_W-1:0]  r_idx;   // Broadcast to every way

    // Registered read outputs, one cycle after r_idx
    logic              r_valid;
    logic [TAG_W-1:0]  r_tag;
    logic [DATA_W-1:0] r_data;

    modport ctrl (
        output we, w_idx, w_tag, w_data, w_valid, r_idx
    );

    modport bank (
        input  we, w_idx, w_tag, w_data, w_valid, r_idx,
        output r_valid, r_tag, r_data
    );

    modport sel (
        input r_valid, r_tag, r_data
    );

endinterface

// File: tb/icache_tb.sv
// Instruction cache testbench with memory model, reference model, checker and watchdog
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
();

    localparam int WAYS       = 2;
    localparam int SETS       = 256;
    localparam int IDX_W      = $clog2(SETS);
    localparam int TAG_W      = ADDR_W - 2 - IDX_W;
    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 10;
    localparam int DRIVE_DLY  = 1;
    localparam int N_RAND     = 300;
    localparam int N_FETCH    = N_RAND + 40;
    localparam int WD_CYCLES  = N_FETCH * 20 + 3 * (SETS + RST_CYCLES + 4);

    logic              clk;
    logic              rst;
    logic              fetch_req;
    logic [ADDR_W-1:0] fetch_addr;
    logic              ready;
    logic              fetch_valid;
    logic [DATA_W-1:0] fetch_data;
    logic              mem_req;
    logic [ADDR_W-1:0] mem_addr;
    logic              mem_rvalid;
    logic [DATA_W-1:0] mem_rdata;

    logic [31:0]       rng_state = 32'd69688;
    logic              ref_valid [WAYS][SETS];
    logic [TAG_W-1:0]  ref_tag [WAYS][SETS];
    int                ref_ptr;

    // Checker bookkeeping for the one fetch in flight
    logic              pending = 1'b0;
    logic              exp_hit = 1'b0;
    logic              mem_seen = 1'b0;
    logic              ready_due = 1'b0;  // Cycle after a response
    logic [31:0]       pend_addr = '0;
    int                req_cycle = 0;
    int                rv_cycle = 0;
    int                cycle_cnt = 0;
    int                resp_cnt = 0;

    tb_clock_gen #(
        .PERIOD_NS (CLK_PERIOD)
    ) i_clock_gen (
        .clk_o (clk)
    );

    icache_top #(
        .WAYS (WAYS),
        .SETS (SETS)
    ) i_dut (
        .clk_i         (clk),
        .rst_i         (rst),
        .fetch_req_i   (fetch_req),
        .fetch_addr_i  (fetch_addr),
        .ready_o       (ready),
        .fetch_valid_o (fetch_valid),
        .fetch_data_o  (fetch_data),
        .mem_req_o     (mem_req),
        .mem_addr_o    (mem_addr),
        .mem_rvalid_i  (mem_rvalid),
        .mem_rdata_i   (mem_rdata)
    );

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Memory contents as a mix of the word address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] w;
        w = {2'b00, addr[31:2]};
        return (w * 32'h9E37_79B1) ^ {w[15:0], w[31:16]} ^ 32'hC0DE_0000;
    endfunction

    // Predicts hit or miss and applies the round-robin fill on a miss
    function automatic logic ref_access(input logic [31:0] addr);
        logic [IDX_W-1:0] idx;
        logic [TAG_W-1:0] tag;
        logic             hit;
        idx = addr[IDX_W+1:2];
        tag = addr[31:IDX_W+2];
        hit = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == tag) begin
                hit = 1'b1;
            end
        end
        if (!hit) begin
            ref_valid[ref_ptr][idx] = 1'b1;
            ref_tag[ref_ptr][idx]   = tag;
            ref_ptr = (ref_ptr + 1) % WAYS;
        end
        return hit;
    endfunction

    function automatic void ref_clear();
        for (int w = 0; w < WAYS; w++) begin
            for (int s = 0; s < SETS; s++) begin
                ref_valid[w][s] = 1'b0;
                ref_tag[w][s]   = '0;
            end
        end
        ref_ptr = 0;
    endfunction

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Checker samples at the falling edge, where outputs are settled
    always @(negedge clk) begin
        if (rst) begin
            pending   = 1'b0;
            ready_due = 1'b0;
        end else begin
            if (ready_due) begin
                check_val(32'(ready), 32'd1, "ready after a response");
            end
            ready_due = fetch_valid;
            if (mem_rvalid) begin
                rv_cycle = cycle_cnt;
            end
            if (mem_req) begin
                check_val(32'(pending), 32'd1, "memory request without a fetch");
                check_val(32'(exp_hit), 32'd0, "memory request on a predicted hit");
                check_val(32'(mem_seen), 32'd0, "second memory request for one fetch");
                check_val(mem_addr, {pend_addr[31:2], 2'b00}, "memory address");
                check_val(32'(cycle_cnt), 32'(req_cycle + 1), "memory request cycle");
                mem_seen = 1'b1;
            end
            if (pending) begin
                check_val(32'(ready), 32'd0, "ready while a fetch is pending");
            end
            if (fetch_valid) begin
                check_val(32'(pending), 32'd1, "response without an honored request");
                check_val(fetch_data, mem_word(pend_addr), "fetch data");
                if (exp_hit) begin
                    check_val(32'(cycle_cnt), 32'(req_cycle + 1), "hit response cycle");
                end else begin
                    check_val(32'(mem_seen), 32'd1, "miss answered without memory request");
                    check_val(32'(cycle_cnt), 32'(rv_cycle + 1), "miss response cycle");
                end
                pending = 1'b0;
                resp_cnt++;
            end
            if (fetch_req && ready) begin
                pend_addr = fetch_addr;
                exp_hit   = ref_access(fetch_addr);
                req_cycle = cycle_cnt;
                mem_seen  = 1'b0;
                pending   = 1'b1;
            end
        end
    end

    initial begin : memory_model
        int          lat;
        logic [31:0] addr;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        forever begin
            @(negedge clk);
            if (!rst && mem_req) begin
                addr = mem_addr;
                lat  = int'(next_rand() % 32'd8) + 1;  // 1 to 8 cycles
                repeat (lat) @(posedge clk);
                #(DRIVE_DLY);
                mem_rvalid = 1'b1;
                mem_rdata  = mem_word(addr);
                @(posedge clk);
                #(DRIVE_DLY);
                mem_rvalid = 1'b0;
                mem_rdata  = '0;
            end
        end
    end

    task automatic apply_reset();
        int n;
        @(posedge clk);
        #(DRIVE_DLY);
        rst = 1'b1;
        ref_clear();
        for (int i = 0; i < RST_CYCLES; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_val(32'({ready, fetch_valid, mem_req}), 32'd0, "outputs in reset");
            end
            @(posedge clk);
            #(DRIVE_DLY);
        end
        rst = 1'b0;
        n = 0;
        @(negedge clk);
        while (!ready && n < 2 * SETS) begin
            n++;
            @(negedge clk);
        end
        check_val(32'(n), 32'(SETS), "invalidate sweep length");
    endtask

    // One fetch, optionally with an extra request while the cache is busy
    task automatic fetch(input logic [31:0] addr, input logic poke);
        int target;
        target = resp_cnt + 1;
        do begin
            @(negedge clk);
        end while (!ready);
        @(posedge clk);
        #(DRIVE_DLY);
        fetch_req  = 1'b1;
        fetch_addr = addr;
        @(posedge clk);
        #(DRIVE_DLY);
        if (poke) begin
            fetch_addr = next_rand() & 32'h0000_0FFC;  // Must be ignored
            @(posedge clk);
            #(DRIVE_DLY);
        end
        fetch_req = 1'b0;
        wait (resp_cnt >= target);
    endtask

    task automatic fetch_and_expect(input logic [31:0] addr, input logic hit);
        fetch(addr, 1'b0);
        check_val(32'(exp_hit), 32'(hit), "predicted hit for a directed fetch");
    endtask

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] addr;
        rst        = 1'b1;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        apply_reset();

        fetch_and_expect(32'h0000_1236, 1'b0);  // Low bits ignored
        fetch_and_expect(32'h0000_1234, 1'b1);
        fetch_and_expect(32'h0000_1237, 1'b1);

        for (int i = 0; i < 8; i++) begin
            fetch_and_expect(32'h0010_0000 + 32'(i) * 32'd4, 1'b0);
        end

        // Three tags sharing set 0x40
        fetch_and_expect(32'h0000_4100, 1'b0);
        fetch_and_expect(32'h0000_8100, 1'b0);
        fetch_and_expect(32'h0000_C100, 1'b0);
        fetch_and_expect(32'h0000_8100, 1'b1);
        fetch_and_expect(32'h0000_4100, 1'b0);
        fetch_and_expect(32'h0000_C100, 1'b1);
        fetch_and_expect(32'h0000_8100, 1'b0);

        for (int i = 0; i < N_RAND; i++) begin
            r    = next_rand();
            addr = (32'(r[1:0]) << (IDX_W + 2)) | (32'(r[4:2]) << 2) | 32'(r[6:5]);
            fetch(addr, r[9:8] == 2'b00);
        end

        fetch(32'h0000_2000, 1'b0);
        fetch_and_expect(32'h0000_2000, 1'b1);
        apply_reset();
        fetch_and_expect(32'h0000_2000, 1'b0);
        fetch_and_expect(32'h0000_1234, 1'b0);

        $display("Simulation passed");
        $finish;
    end

    initial begin : watchdog
        #(WD_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, a fetch was never answered", WD_CYCLES);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

endmodule

// File: tb/tb_clock_gen.sv
// Testbench clock source toggling at a fixed period given in ns
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

// File: verilog.f
src/icache_pkg.sv
src/icache_way_if.sv
src/icache_way_bank.sv
src/icache_hit_select.sv
src/icache_ctrl.sv
src/icache_top.sv
tb/tb_clock_gen.sv
tb/icache_tb.sv
